// ==== src/axi_lite_pkg.sv ====
// AXI4-Lite control bus widths and response codes shared by the bridge
package axi_lite_pkg;

    // Control address width, byte addressed
    localparam int ADDR_W = 32;

    // Control data width
    localparam int DATA_W = 32;

    // One strobe bit per data byte
    localparam int STRB_W = DATA_W / 8;

    // Width of BRESP and RRESP
    localparam int RESP_W = 2;

    // Normal access success
    // The bridge never reports SLVERR or DECERR
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

// ==== src/vswitch_pkg.sv ====
// Virtual switch count and the control address layout used to pick a switch
package vswitch_pkg;

    // Number of virtual switches behind the bridge
    localparam int NUM_SW = 4;

    // Bits needed to name one switch
    localparam int SEL_W = 2;

    // Register offset bits above the switch select
    localparam int OFFSET_W = axi_lite_pkg::ADDR_W - SEL_W;

    // Index of one virtual switch
    typedef logic [SEL_W-1:0] sw_idx_t;

    // Select and offset view of the control address
    // Select sits in the two low address bits
    typedef struct packed {
        logic [OFFSET_W-1:0] offset;
        sw_idx_t             sel;
    } ctrl_addr_fields_t;

    // One control address, read two ways
    // Flat word goes out to the switches unchanged
    // Field view is decoded by the read router
    typedef union packed {
        logic [axi_lite_pkg::ADDR_W-1:0] flat;
        ctrl_addr_fields_t               fields;
    } ctrl_addr_u;

endpackage

// ==== src/ctrl_write_fanout.sv ====
// Write channel of the bridge: accepts a broadcast write and returns its response
`timescale 1ns/1ps

module ctrl_write_fanout (
    input  logic                               M_AXI_ACLK,
    input  logic                               M_AXI_ARESETN,
    // Master write address and data valids
    input  logic                               awvalid,
    input  logic                               wvalid,
    // Master ready for the write response
    input  logic                               bready,
    // Per switch ready for address and data
    input  logic [vswitch_pkg::NUM_SW-1:0]     sw_awready,
    input  logic [vswitch_pkg::NUM_SW-1:0]     sw_wready,
    // Handshake and response back to the master
    output logic                               awready,
    output logic                               wready,
    output logic                               bvalid,
    output logic [axi_lite_pkg::RESP_W-1:0]    bresp
);

    import axi_lite_pkg::*;

    // Any switch ready on each channel
    logic any_awready;
    logic any_wready;

    // Single cycle accept pulse for address and data together
    logic accept_q;

    // Request for a new accept pulse
    logic accept_req;

    // Handshake seen by the master on this edge
    logic wr_xfer;

    assign any_awready = |sw_awready;
    assign any_wready  = |sw_wready;

    // Both halves of the write must be offered
    // No new write while a response is pending
    // Pulse never lasts two cycles
    assign accept_req = awvalid && wvalid && any_awready && any_wready
                        && !bvalid && !accept_q;

    // Address and data are accepted on the same edge
    assign wr_xfer = accept_q && awvalid && wvalid;

    assign awready = accept_q;
    assign wready  = accept_q;

    // Accept pulse and response valid
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            accept_q <= 1'b0;
            bvalid   <= 1'b0;
        end
        else
        begin
            accept_q <= accept_req;

            // Response follows the handshake by one edge
            // and waits for the master to take it
            if (wr_xfer)
            begin
                bvalid <= 1'b1;
            end
            else if (bvalid && bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    // Response code, loaded with the handshake
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (wr_xfer)
        begin
            // Switch responses are not merged, always OKAY
            bresp <= RESP_OKAY;
        end
    end

endmodule

// ==== src/ctrl_read_select.sv ====
// Read channel of the bridge: routes a read to one switch and returns its data
`timescale 1ns/1ps

module ctrl_read_select (
    input  logic                                   M_AXI_ACLK,
    input  logic                                   M_AXI_ARESETN,
    // Master read address channel
    input  vswitch_pkg::ctrl_addr_u                araddr,
    input  logic                                   arvalid,
    // Master ready for read data
    input  logic                                   rready,
    // Per switch read channel inputs
    input  logic [vswitch_pkg::NUM_SW-1:0]         sw_arready,
    input  logic [vswitch_pkg::NUM_SW-1:0]         sw_rvalid,
    input  logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::DATA_W-1:0] sw_rdata,
    // Master side handshake and returned data
    output logic                                   arready,
    output logic                                   rvalid,
    output logic [axi_lite_pkg::DATA_W-1:0]        rdata,
    output logic [axi_lite_pkg::RESP_W-1:0]        rresp,
    // Per switch read channel outputs
    output logic [vswitch_pkg::NUM_SW-1:0]         sw_arvalid,
    output logic [vswitch_pkg::NUM_SW-1:0]         sw_rready
);

    import axi_lite_pkg::*;
    import vswitch_pkg::*;

    // Switch named by the incoming address
    sw_idx_t ar_sel;

    // Switch that owns the read in flight
    sw_idx_t sel_q;

    // Read accepted and not yet returned to the master
    logic rd_busy;

    // Switch accepted the address on this edge
    logic ar_accept;

    // Selected switch hands over its data on this edge
    logic r_capture;

    assign ar_sel = araddr.fields.sel;

    // Steer arvalid to the addressed switch only
    // Held off while a read is in flight
    always_comb
    begin
        for (int i = 0; i < NUM_SW; i++)
        begin
            sw_arvalid[i] = arvalid && !rd_busy && (ar_sel == sw_idx_t'(i));
        end
    end

    // Switch side address transfer
    assign ar_accept = |(sw_arvalid & sw_arready);

    // Ready to the owning switch while the return register is empty
    // Kept low during the master's arready cycle so data never beats the address
    always_comb
    begin
        for (int i = 0; i < NUM_SW; i++)
        begin
            sw_rready[i] = rd_busy && !arready && !rvalid && (sel_q == sw_idx_t'(i));
        end
    end

    assign r_capture = |(sw_rvalid & sw_rready);

    // Read tracking and master side valids
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            arready <= 1'b0;
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            // One cycle pulse, rd_busy blocks a repeat
            arready <= ar_accept;

            if (ar_accept)
            begin
                rd_busy <= 1'b1;
            end
            else if (rvalid && rready)
            begin
                rd_busy <= 1'b0;
            end

            // Hold data until the master takes it
            if (r_capture)
            begin
                rvalid <= 1'b1;
            end
            else if (rready)
            begin
                rvalid <= 1'b0;
            end
        end
    end

    // Select latch and return data register
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (ar_accept)
        begin
            sel_q <= ar_sel;
        end
        if (r_capture)
        begin
            rdata <= sw_rdata[sel_q];
            // Switch rresp is not forwarded
            rresp <= RESP_OKAY;
        end
    end

endmodule

// ==== src/vswitch_ctrl_bridge.sv ====
// Control bridge from one AXI4-Lite master to four virtual switch register blocks
`timescale 1ns/1ps

module vswitch_ctrl_bridge (
    input  logic                                 M_AXI_ACLK,
    input  logic                                 M_AXI_ARESETN,
    // Master write channels
    input  logic [axi_lite_pkg::ADDR_W-1:0]      M_AXI_AWADDR,
    input  logic                                 M_AXI_AWVALID,
    input  logic [axi_lite_pkg::DATA_W-1:0]      M_AXI_WDATA,
    input  logic [axi_lite_pkg::STRB_W-1:0]      M_AXI_WSTRB,
    input  logic                                 M_AXI_WVALID,
    input  logic                                 M_AXI_BREADY,
    output logic                                 M_AXI_AWREADY,
    output logic                                 M_AXI_WREADY,
    output logic [axi_lite_pkg::RESP_W-1:0]      M_AXI_BRESP,
    output logic                                 M_AXI_BVALID,
    // Master read channels
    input  logic [axi_lite_pkg::ADDR_W-1:0]      M_AXI_ARADDR,
    input  logic                                 M_AXI_ARVALID,
    input  logic                                 M_AXI_RREADY,
    output logic                                 M_AXI_ARREADY,
    output logic [axi_lite_pkg::DATA_W-1:0]      M_AXI_RDATA,
    output logic [axi_lite_pkg::RESP_W-1:0]      M_AXI_RRESP,
    output logic                                 M_AXI_RVALID,
    // Switch ports, one slice per switch
    output logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::ADDR_W-1:0] S_AXI_AWADDR,
    output logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_AWVALID,
    output logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::DATA_W-1:0] S_AXI_WDATA,
    output logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::STRB_W-1:0] S_AXI_WSTRB,
    output logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_WVALID,
    output logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_BREADY,
    output logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::ADDR_W-1:0] S_AXI_ARADDR,
    output logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_ARVALID,
    output logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_RREADY,
    input  logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_ARREADY,
    input  logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::DATA_W-1:0] S_AXI_RDATA,
    input  logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::RESP_W-1:0] S_AXI_RRESP,
    input  logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_RVALID,
    input  logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_WREADY,
    input  logic [vswitch_pkg::NUM_SW-1:0][axi_lite_pkg::RESP_W-1:0] S_AXI_BRESP,
    input  logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_BVALID,
    input  logic [vswitch_pkg::NUM_SW-1:0]                           S_AXI_AWREADY
);

    import vswitch_pkg::*;

    // Read address seen through the select and offset view
    ctrl_addr_u rd_addr;

    assign rd_addr.flat = M_AXI_ARADDR;

    // Write channels go to every switch unchanged
    assign S_AXI_AWADDR  = {NUM_SW{M_AXI_AWADDR}};
    assign S_AXI_AWVALID = {NUM_SW{M_AXI_AWVALID}};
    assign S_AXI_WDATA   = {NUM_SW{M_AXI_WDATA}};
    assign S_AXI_WSTRB   = {NUM_SW{M_AXI_WSTRB}};
    assign S_AXI_WVALID  = {NUM_SW{M_AXI_WVALID}};
    assign S_AXI_BREADY  = {NUM_SW{M_AXI_BREADY}};

    // Read address is broadcast, arvalid decides who answers
    assign S_AXI_ARADDR  = {NUM_SW{rd_addr.flat}};

    // S_AXI_BRESP, S_AXI_BVALID and S_AXI_RRESP stay unconnected
    // Bridge answers OKAY on its own

    // Write accept and response
    ctrl_write_fanout i_write (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .awvalid       (M_AXI_AWVALID),
        .wvalid        (M_AXI_WVALID),
        .bready        (M_AXI_BREADY),
        .sw_awready    (S_AXI_AWREADY),
        .sw_wready     (S_AXI_WREADY),
        .awready       (M_AXI_AWREADY),
        .wready        (M_AXI_WREADY),
        .bvalid        (M_AXI_BVALID),
        .bresp         (M_AXI_BRESP)
    );

    // Read routing and return register
    ctrl_read_select i_read (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .araddr        (rd_addr),
        .arvalid       (M_AXI_ARVALID),
        .rready        (M_AXI_RREADY),
        .sw_arready    (S_AXI_ARREADY),
        .sw_rvalid     (S_AXI_RVALID),
        .sw_rdata      (S_AXI_RDATA),
        .arready       (M_AXI_ARREADY),
        .rvalid        (M_AXI_RVALID),
        .rdata         (M_AXI_RDATA),
        .rresp         (M_AXI_RRESP),
        .sw_arvalid    (S_AXI_ARVALID),
        .sw_rready     (S_AXI_RREADY)
    );

endmodule

// ==== sim/vswitch_model.sv ====
// Behavioral virtual switch register block with a stall input on its read address channel
`timescale 1ns/1ps

module vswitch_model #(
    parameter logic [1:0] IDX = 2'd0
) (
    input  logic                                M_AXI_ACLK,
    input  logic                                M_AXI_ARESETN,
    // Write channels from the bridge
    input  logic [axi_lite_pkg::ADDR_W-1:0]     awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_lite_pkg::DATA_W-1:0]     wdata,
    input  logic [axi_lite_pkg::STRB_W-1:0]     wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [axi_lite_pkg::RESP_W-1:0]     bresp,
    output logic                                bvalid,
    input  logic                                bready,
    // Read channels from the bridge
    input  logic [axi_lite_pkg::ADDR_W-1:0]     araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [axi_lite_pkg::DATA_W-1:0]     rdata,
    output logic [axi_lite_pkg::RESP_W-1:0]     rresp,
    output logic                                rvalid,
    input  logic                                rready,
    // Holds arready low while set
    input  logic                                stall
);

    import axi_lite_pkg::*;

    // Sixteen words, picked by address bits 5:2
    logic [DATA_W-1:0] regs [16];

    // Always ready for writes
    assign awready = 1'b1;
    assign wready  = 1'b1;

    // Bridge answers writes itself, no response from here
    assign bvalid = 1'b0;
    assign bresp  = RESP_OKAY;

    // One read at a time
    assign arready = !stall && !rvalid;

    // Register file, rewritten every cycle the write is offered
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            for (int i = 0; i < 16; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (awvalid && wvalid)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (wstrb[b])
                begin
                    regs[awaddr[5:2]][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data is tagged with the switch index in the top nibble
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end
        else if (arvalid && arready)
        begin
            rvalid <= 1'b1;
            rdata  <= regs[araddr[5:2]] ^ {2'b00, IDX, 28'h0};
            rresp  <= RESP_OKAY;
        end
        else if (rvalid && rready)
        begin
            rvalid <= 1'b0;
        end
    end

endmodule

// ==== sim/vswitch_ctrl_bridge_chk.sv ====
// Handshake assertions for the control bridge, bound into its top level
`timescale 1ns/1ps

module vswitch_ctrl_bridge_chk (
    input  logic                                M_AXI_ACLK,
    input  logic                                M_AXI_ARESETN,
    input  logic                                awready,
    input  logic                                bvalid,
    input  logic                                bready,
    input  logic                                rvalid,
    input  logic                                rready,
    input  logic [axi_lite_pkg::DATA_W-1:0]     rdata,
    input  logic [vswitch_pkg::NUM_SW-1:0]      sw_arvalid
);

    // Accept pulse lasts one cycle
    awready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        awready |=> !awready)
        else $error("AWREADY high in two consecutive cycles");

    // Write response waits for the master
    bvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        bvalid && !bready |=> bvalid)
        else $error("BVALID dropped before BREADY");

    // Read data held under back-pressure
    rvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("RVALID or RDATA changed while RREADY low");

    // Only one switch sees a read address
    arvalid_onehot: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        $onehot0(sw_arvalid))
        else $error("More than one switch arvalid high");

endmodule

bind vswitch_ctrl_bridge vswitch_ctrl_bridge_chk i_chk (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .awready       (M_AXI_AWREADY),
    .bvalid        (M_AXI_BVALID),
    .bready        (M_AXI_BREADY),
    .rvalid        (M_AXI_RVALID),
    .rready        (M_AXI_RREADY),
    .rdata         (M_AXI_RDATA),
    .sw_arvalid    (S_AXI_ARVALID)
);

// ==== sim/tb_vswitch_ctrl_bridge.sv ====
// Directed testbench for the control bridge with four behavioral switches
`timescale 1ns/1ps

module tb_vswitch_ctrl_bridge;

    import axi_lite_pkg::*;
    import vswitch_pkg::*;

    localparam int NUM_TESTS = 6;

    logic clk;
    logic rstn;
    // Master side
    logic [ADDR_W-1:0] awaddr;
    logic awvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic wvalid;
    logic bready;
    logic awready;
    logic wready;
    logic [RESP_W-1:0] bresp;
    logic bvalid;
    logic [ADDR_W-1:0] araddr;
    logic arvalid;
    logic rready;
    logic arready;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
    logic rvalid;
    // Switch side
    logic [NUM_SW-1:0][ADDR_W-1:0] s_awaddr;
    logic [NUM_SW-1:0] s_awvalid;
    logic [NUM_SW-1:0][DATA_W-1:0] s_wdata;
    logic [NUM_SW-1:0][STRB_W-1:0] s_wstrb;
    logic [NUM_SW-1:0] s_wvalid;
    logic [NUM_SW-1:0] s_bready;
    logic [NUM_SW-1:0][ADDR_W-1:0] s_araddr;
    logic [NUM_SW-1:0] s_arvalid;
    logic [NUM_SW-1:0] s_rready;
    logic [NUM_SW-1:0] s_arready;
    logic [NUM_SW-1:0][DATA_W-1:0] s_rdata;
    logic [NUM_SW-1:0][RESP_W-1:0] s_rresp;
    logic [NUM_SW-1:0] s_rvalid;
    logic [NUM_SW-1:0] s_wready;
    logic [NUM_SW-1:0][RESP_W-1:0] s_bresp;
    logic [NUM_SW-1:0] s_bvalid;
    logic [NUM_SW-1:0] s_awready;
    logic [NUM_SW-1:0] stall;

    // Words written so far, by register offset
    logic [DATA_W-1:0] exp_mem [16];

    vswitch_ctrl_bridge i_dut (
        .M_AXI_ACLK (clk), .M_AXI_ARESETN (rstn),
        .M_AXI_AWADDR (awaddr), .M_AXI_AWVALID (awvalid), .M_AXI_WDATA (wdata),
        .M_AXI_WSTRB (wstrb), .M_AXI_WVALID (wvalid), .M_AXI_BREADY (bready),
        .M_AXI_AWREADY (awready), .M_AXI_WREADY (wready), .M_AXI_BRESP (bresp),
        .M_AXI_BVALID (bvalid), .M_AXI_ARADDR (araddr), .M_AXI_ARVALID (arvalid),
        .M_AXI_RREADY (rready), .M_AXI_ARREADY (arready), .M_AXI_RDATA (rdata),
        .M_AXI_RRESP (rresp), .M_AXI_RVALID (rvalid),
        .S_AXI_AWADDR (s_awaddr), .S_AXI_AWVALID (s_awvalid), .S_AXI_WDATA (s_wdata),
        .S_AXI_WSTRB (s_wstrb), .S_AXI_WVALID (s_wvalid), .S_AXI_BREADY (s_bready),
        .S_AXI_ARADDR (s_araddr), .S_AXI_ARVALID (s_arvalid), .S_AXI_RREADY (s_rready),
        .S_AXI_ARREADY (s_arready), .S_AXI_RDATA (s_rdata), .S_AXI_RRESP (s_rresp),
        .S_AXI_RVALID (s_rvalid), .S_AXI_WREADY (s_wready), .S_AXI_BRESP (s_bresp),
        .S_AXI_BVALID (s_bvalid), .S_AXI_AWREADY (s_awready)
    );

    // One model per switch, tagged with its index
    for (genvar g = 0; g < NUM_SW; g++)
    begin : gen_sw
        vswitch_model #(.IDX (2'(g))) i_sw (
            .M_AXI_ACLK (clk), .M_AXI_ARESETN (rstn),
            .awaddr (s_awaddr[g]), .awvalid (s_awvalid[g]), .awready (s_awready[g]),
            .wdata (s_wdata[g]), .wstrb (s_wstrb[g]), .wvalid (s_wvalid[g]),
            .wready (s_wready[g]), .bresp (s_bresp[g]), .bvalid (s_bvalid[g]),
            .bready (s_bready[g]), .araddr (s_araddr[g]), .arvalid (s_arvalid[g]),
            .arready (s_arready[g]), .rdata (s_rdata[g]), .rresp (s_rresp[g]),
            .rvalid (s_rvalid[g]), .rready (s_rready[g]), .stall (stall[g])
        );
    end

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Budget of 200 cycles per test
    initial
    begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        $display("Regression failed");
        $fatal(1);
    end

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Expected read value: stored word tagged with the switch index
    function automatic logic [31:0] expected_read(input int k, input int s);
        expected_read = exp_mem[k] ^ (32'(s) << 28);
    endfunction

    task automatic do_write(input int k, input logic [31:0] data, input string test);
        awaddr  = 32'(k) << 2;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!awready) @(negedge clk);
        // Data is accepted together with the address
        check_value(test, 32'd1, 32'(wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_value(test, 32'(RESP_OKAY), 32'(bresp));
        // Every switch sees the master's bready
        check_value(test, 32'({NUM_SW{1'b1}}), 32'(s_bready));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic start_read(input int k, input int s);
        araddr  = (32'(k) << 2) | 32'(s);
        arvalid = 1'b1;
    endtask

    task automatic finish_read(input logic [31:0] expected, input string test);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge clk);
        check_value(test, expected, rdata);
        check_value(test, 32'(RESP_OKAY), 32'(rresp));
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic reset_outputs();
        repeat (16)
        begin
            @(negedge clk);
            check_value("reset", 32'd0, 32'({awready, wready, bvalid, arready, rvalid}));
        end
        rstn = 1'b1;
        @(negedge clk);
        check_value("reset", 32'd0, 32'({awready, wready, bvalid, arready, rvalid}));
    endtask

    task automatic broadcast_write();
        for (int k = 0; k < 8; k++)
        begin
            exp_mem[k] = $urandom;
            do_write(k, exp_mem[k], "write_broadcast");
            check_value("write_broadcast", exp_mem[k], gen_sw[0].i_sw.regs[k]);
            check_value("write_broadcast", exp_mem[k], gen_sw[1].i_sw.regs[k]);
            check_value("write_broadcast", exp_mem[k], gen_sw[2].i_sw.regs[k]);
            check_value("write_broadcast", exp_mem[k], gen_sw[3].i_sw.regs[k]);
        end
    endtask

    task automatic route_reads();
        for (int k = 0; k < 8; k += 2)
        begin
            for (int s = 0; s < NUM_SW; s++)
            begin
                start_read(k, s);
                finish_read(expected_read(k, s), "read_routing");
            end
        end
    endtask

    task automatic hold_write_response();
        exp_mem[8] = $urandom;
        exp_mem[9] = $urandom;
        awaddr  = 32'd8 << 2;
        wdata   = exp_mem[8];
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        while (!awready) @(negedge clk);
        @(negedge clk);
        // Second write offered while the first response waits
        awaddr = 32'd9 << 2;
        wdata  = exp_mem[9];
        while (!bvalid) @(negedge clk);
        repeat (10)
        begin
            check_value("write_backpressure", 32'd1, 32'(bvalid));
            check_value("write_backpressure", 32'(RESP_OKAY), 32'(bresp));
            check_value("write_backpressure", 32'd0, 32'(awready));
            check_value("write_backpressure", 32'd0, 32'(wready));
            check_value("write_backpressure", 32'd0, 32'(s_bready));
            @(negedge clk);
        end
        bready = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_value("write_backpressure", 32'(RESP_OKAY), 32'(bresp));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic hold_read_data();
        start_read(2, 1);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (10)
        begin
            check_value("read_backpressure", 32'd1, 32'(rvalid));
            check_value("read_backpressure", expected_read(2, 1), rdata);
            @(negedge clk);
        end
        rready = 1'b1;
        @(negedge clk);
        check_value("read_backpressure", 32'd0, 32'(rvalid));
        rready = 1'b0;
    endtask

    task automatic stall_switch();
        stall[3] = 1'b1;
        start_read(9, 3);
        repeat (10)
        begin
            @(negedge clk);
            check_value("switch_stall", 32'd0, 32'(arready));
        end
        stall[3] = 1'b0;
        finish_read(expected_read(9, 3), "switch_stall");
    endtask

    initial
    begin
        void'($urandom(32'h95f2_0685));
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        stall   = '0;
        for (int i = 0; i < 16; i++)
        begin
            exp_mem[i] = '0;
        end

        reset_outputs();
        broadcast_write();
        route_reads();
        hold_write_response();
        hold_read_data();
        stall_switch();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== vswitch_ctrl_bridge.f ====
src/axi_lite_pkg.sv
src/vswitch_pkg.sv
src/ctrl_write_fanout.sv
src/ctrl_read_select.sv
src/vswitch_ctrl_bridge.sv
sim/vswitch_model.sv
sim/vswitch_ctrl_bridge_chk.sv
sim/tb_vswitch_ctrl_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_vswitch_ctrl_bridge \
    -f vswitch_ctrl_bridge.f \
    --Mdir obj_dir -o tb_sim

# Simulator exits non-zero on failure; the log decides
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    exit 1
fi
exit 0
